// File: project.f
+incdir+source
source/axi_lite_pkg.sv
source/bram_pkg.sv
source/dual_port_ram.sv
source/axi_bram_ctrl.sv
source/mem_subsystem_top.sv
tb/mem_subsystem_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps \
	-f project.f \
	--top-module mem_subsystem_tb \
	-o mem_subsystem_tb
./obj_dir/mem_subsystem_tb

// File: source/axi_bram_ctrl.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module axi_bram_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,

	input  axi_lite_pkg::axi_aw_t aw,
	input  logic                 awvalid,
	output logic                 awready,

	input  axi_lite_pkg::axi_w_t  w,
	input  logic                 wvalid,
	output logic                 wready,

	output axi_lite_pkg::resp_t   bresp,
	output logic                 bvalid,
	input  logic                 bready,

	input  axi_lite_pkg::axi_ar_t ar,
	input  logic                 arvalid,
	output logic                 arready,

	output axi_lite_pkg::axi_r_t  r,
	output logic                 rvalid,
	input  logic                 rready,

	output bram_pkg::bram_req_t   bram,
	input  logic [`DATA_W-1:0]   bram_rdata
);
	import axi_lite_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_write,
		st_write_resp,
		st_read,
		st_read_wait,
		st_read_resp
	} state_t;

	localparam int unsigned MEM_BYTES = `DEPTH_WORDS * 4;

	state_t state;
	logic last_wr;
	logic wr_req, rd_req;
	logic grant_wr, grant_rd;

	logic [`ADDR_W-1:0] addr_q;
	logic [`DATA_W-1:0] wdata_q;
	logic [`STRB_W-1:0] strb_q;
	logic [`DATA_W-1:0] rdata_q;
	logic [`DATA_W-1:0] rd_word;
	logic err_q;

	function automatic logic out_of_range(logic [`ADDR_W-1:0] addr);
		return 32'(addr) >= MEM_BYTES;
	endfunction

	assign wr_req = awvalid && wvalid;
	assign rd_req = arvalid;

	// on a tie the kind not served last goes first
	assign grant_wr = (state == st_idle) && wr_req && (!rd_req || !last_wr);
	assign grant_rd = (state == st_idle) && rd_req && (!wr_req || last_wr);

	assign awready = grant_wr;
	assign wready  = grant_wr;
	assign arready = grant_rd;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= st_idle;
			last_wr <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (grant_wr) begin
						state   <= st_write;
						last_wr <= 1'b1;
					end else if (grant_rd) begin
						state   <= st_read;
						last_wr <= 1'b0;
					end
				end
				st_write: begin
					state <= bready ? st_idle : st_write_resp;
				end
				st_write_resp: begin
					if (bready) begin
						state <= st_idle;
					end
				end
				st_read: begin
					state <= st_read_wait;
				end
				st_read_wait: begin
					state <= rready ? st_idle : st_read_resp;
				end
				st_read_resp: begin
					if (rready) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// latch the request at the address handshake
	always_ff @(posedge clk) begin
		if (grant_wr) begin
			addr_q  <= aw.addr;
			wdata_q <= w.data;
			strb_q  <= w.strb;
			err_q   <= out_of_range(aw.addr);
		end else if (grant_rd) begin
			addr_q <= ar.addr;
			err_q  <= out_of_range(ar.addr);
		end
		// held here while rready is low
		if (state == st_read_wait) begin
			rdata_q <= rd_word;
		end
	end

	always_comb begin
		bram       = '0;
		bram.addr  = addr_q[`WORD_ADDR_W+1:2];
		bram.wdata = wdata_q;
		if (state == st_write && !err_q) begin
			bram.en = 1'b1;
			bram.we = strb_q;
		end else if (state == st_read && !err_q) begin
			bram.en = 1'b1;
		end
	end

	// out of range reads return zero
	assign rd_word = err_q ? '0 : bram_rdata;

	assign bvalid = (state == st_write) || (state == st_write_resp);
	assign bresp  = err_q ? SLVERR : OKAY;

	assign rvalid = (state == st_read_wait) || (state == st_read_resp);
	assign r.data = (state == st_read_wait) ? rd_word : rdata_q;
	assign r.resp = err_q ? SLVERR : OKAY;

endmodule

// File: source/axi_lite_pkg.sv
`include "mem_macros.svh"

package axi_lite_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_t;

	// write address channel payload
	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		logic [`PROT_W-1:0] prot;
	} axi_aw_t;

	typedef struct packed {
		logic [`DATA_W-1:0] data;
		logic [`STRB_W-1:0] strb;
	} axi_w_t;

	// read address channel payload
	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		logic [`PROT_W-1:0] prot;
	} axi_ar_t;

	typedef struct packed {
		logic [`DATA_W-1:0] data;
		resp_t              resp;
	} axi_r_t;

endpackage

// File: source/bram_pkg.sv
`include "mem_macros.svh"

package bram_pkg;

	// one request on a block-RAM port
	typedef struct packed {
		logic                    en;
		logic [`STRB_W-1:0]      we;
		logic [`WORD_ADDR_W-1:0] addr;
		logic [`DATA_W-1:0]      wdata;
	} bram_req_t;

endpackage

// File: source/dual_port_ram.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module dual_port_ram (
	input  logic                clk,
	input  bram_pkg::bram_req_t port_a,
	input  bram_pkg::bram_req_t port_b,
	output logic [`DATA_W-1:0]  rdata_a,
	output logic [`DATA_W-1:0]  rdata_b
);

	logic [`DATA_W-1:0] mem [`DEPTH_WORDS];

	// read-first on both ports
	always_ff @(posedge clk) begin
		if (port_a.en) begin
			rdata_a <= mem[port_a.addr];
		end
		if (port_b.en) begin
			rdata_b <= mem[port_b.addr];
		end
	end

	// port b comes last so it wins a collision
	always_ff @(posedge clk) begin
		for (int i = 0; i < `STRB_W; i++) begin
			if (port_a.en && port_a.we[i]) begin
				mem[port_a.addr][8*i +: 8] <= port_a.wdata[8*i +: 8];
			end
			if (port_b.en && port_b.we[i]) begin
				mem[port_b.addr][8*i +: 8] <= port_b.wdata[8*i +: 8];
			end
		end
	end

endmodule

// File: source/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// byte address seen on the AXI side
`define ADDR_W 16

`define DATA_W 32

// one strobe bit per byte lane
`define STRB_W (`DATA_W / 8)

`define PROT_W 3

// storage size in words
`define DEPTH_WORDS 1024

`define WORD_ADDR_W 10

`endif

// File: source/mem_subsystem_top.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsystem_top (
	input  logic                  clk,
	input  logic                  rst_n,

	// instruction memory port
	input  axi_lite_pkg::axi_aw_t imem_aw,
	input  logic                  imem_awvalid,
	output logic                  imem_awready,
	input  axi_lite_pkg::axi_w_t  imem_w,
	input  logic                  imem_wvalid,
	output logic                  imem_wready,
	output axi_lite_pkg::resp_t   imem_bresp,
	output logic                  imem_bvalid,
	input  logic                  imem_bready,
	input  axi_lite_pkg::axi_ar_t imem_ar,
	input  logic                  imem_arvalid,
	output logic                  imem_arready,
	output axi_lite_pkg::axi_r_t  imem_r,
	output logic                  imem_rvalid,
	input  logic                  imem_rready,

	// data memory port
	input  axi_lite_pkg::axi_aw_t dmem_aw,
	input  logic                  dmem_awvalid,
	output logic                  dmem_awready,
	input  axi_lite_pkg::axi_w_t  dmem_w,
	input  logic                  dmem_wvalid,
	output logic                  dmem_wready,
	output axi_lite_pkg::resp_t   dmem_bresp,
	output logic                  dmem_bvalid,
	input  logic                  dmem_bready,
	input  axi_lite_pkg::axi_ar_t dmem_ar,
	input  logic                  dmem_arvalid,
	output logic                  dmem_arready,
	output axi_lite_pkg::axi_r_t  dmem_r,
	output logic                  dmem_rvalid,
	input  logic                  dmem_rready
);
	import bram_pkg::*;

	bram_req_t bram_a;
	bram_req_t bram_b;
	logic [`DATA_W-1:0] rdata_a;
	logic [`DATA_W-1:0] rdata_b;

	axi_bram_ctrl imem_ctrl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.aw         (imem_aw),
		.awvalid    (imem_awvalid),
		.awready    (imem_awready),
		.w          (imem_w),
		.wvalid     (imem_wvalid),
		.wready     (imem_wready),
		.bresp      (imem_bresp),
		.bvalid     (imem_bvalid),
		.bready     (imem_bready),
		.ar         (imem_ar),
		.arvalid    (imem_arvalid),
		.arready    (imem_arready),
		.r          (imem_r),
		.rvalid     (imem_rvalid),
		.rready     (imem_rready),
		.bram       (bram_a),
		.bram_rdata (rdata_a)
	);

	axi_bram_ctrl dmem_ctrl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.aw         (dmem_aw),
		.awvalid    (dmem_awvalid),
		.awready    (dmem_awready),
		.w          (dmem_w),
		.wvalid     (dmem_wvalid),
		.wready     (dmem_wready),
		.bresp      (dmem_bresp),
		.bvalid     (dmem_bvalid),
		.bready     (dmem_bready),
		.ar         (dmem_ar),
		.arvalid    (dmem_arvalid),
		.arready    (dmem_arready),
		.r          (dmem_r),
		.rvalid     (dmem_rvalid),
		.rready     (dmem_rready),
		.bram       (bram_b),
		.bram_rdata (rdata_b)
	);

	// imem drives port a and dmem port b
	dual_port_ram ram_i (
		.clk     (clk),
		.port_a  (bram_a),
		.port_b  (bram_b),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

endmodule

// File: tb/mem_subsystem_tb.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsystem_tb;
	import axi_lite_pkg::*;

	logic clk = 1'b0;
	logic rst_n;
	axi_aw_t [1:0] aw;
	axi_w_t [1:0] w;
	axi_ar_t [1:0] ar;
	axi_r_t [1:0] r;
	logic [1:0][1:0] bresp;
	logic [1:0] awvalid, awready, wvalid, wready, bvalid, bready;
	logic [1:0] arvalid, arready, rvalid, rready;

	logic [15:0] lfsr = 16'd38;
	int cycle = 0;
	int wr_lat;
	int rd_lat;
	string names [2] = '{"imem", "dmem"};

	// reference memory and accepted requests not yet committed
	logic [`DATA_W-1:0] model [`DEPTH_WORDS];
	logic [1:0] wr_v = '0;
	logic [1:0] rd_v = '0;
	logic [1:0] exp_b_v = '0;
	logic [1:0] exp_r_v = '0;
	logic [1:0][`ADDR_W-1:0] wr_addr, rd_addr;
	logic [1:0][`DATA_W-1:0] wr_data, exp_rdata;
	logic [1:0][`STRB_W-1:0] wr_strb;
	logic [1:0][1:0] exp_bresp, exp_rresp;

	mem_subsystem_top dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_aw      (aw[0]),
		.imem_awvalid (awvalid[0]),
		.imem_awready (awready[0]),
		.imem_w       (w[0]),
		.imem_wvalid  (wvalid[0]),
		.imem_wready  (wready[0]),
		.imem_bresp   (bresp[0]),
		.imem_bvalid  (bvalid[0]),
		.imem_bready  (bready[0]),
		.imem_ar      (ar[0]),
		.imem_arvalid (arvalid[0]),
		.imem_arready (arready[0]),
		.imem_r       (r[0]),
		.imem_rvalid  (rvalid[0]),
		.imem_rready  (rready[0]),
		.dmem_aw      (aw[1]),
		.dmem_awvalid (awvalid[1]),
		.dmem_awready (awready[1]),
		.dmem_w       (w[1]),
		.dmem_wvalid  (wvalid[1]),
		.dmem_wready  (wready[1]),
		.dmem_bresp   (bresp[1]),
		.dmem_bvalid  (bvalid[1]),
		.dmem_bready  (bready[1]),
		.dmem_ar      (ar[1]),
		.dmem_arvalid (arvalid[1]),
		.dmem_arready (arready[1]),
		.dmem_r       (r[1]),
		.dmem_rvalid  (rvalid[1]),
		.dmem_rready  (rready[1])
	);

	always #20 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic out_of_range(input logic [`ADDR_W-1:0] a);
		return int'(a) >= `DEPTH_WORDS * 4;
	endfunction

	// 16 word window so the ports collide often
	// about 1 address in 8 lands out of range
	function automatic logic [`ADDR_W-1:0] random_addr();
		logic [3:0] hi;
		hi = (rand_bits(3) == 0) ? {3'(rand_bits(3)), 1'b1} : 4'h0;
		return {hi, 6'd0, 4'(rand_bits(4)), 2'b00};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string what);
		$display("** FAIL **");
		$fatal(1, "%s", what);
	endtask

	// reads see the old word, then port a writes, then port b
	always @(negedge clk) begin
		if (rst_n) begin
			for (int p = 0; p < 2; p++) begin
				if (rd_v[p]) begin
					exp_rdata[p] = out_of_range(rd_addr[p]) ? '0 :
						model[rd_addr[p][`WORD_ADDR_W+1:2]];
					exp_rresp[p] = out_of_range(rd_addr[p]) ? SLVERR : OKAY;
					exp_r_v[p] = 1'b1;
					rd_v[p] = 1'b0;
				end
			end
			for (int p = 0; p < 2; p++) begin
				for (int i = 0; i < `STRB_W; i++) begin
					if (wr_v[p] && !out_of_range(wr_addr[p]) && wr_strb[p][i])
						model[wr_addr[p][`WORD_ADDR_W+1:2]][8*i +: 8] = wr_data[p][8*i +: 8];
				end
				wr_v[p] = 1'b0;
			end
			for (int p = 0; p < 2; p++) begin
				if ((awvalid[p] && awready[p]) != (wvalid[p] && wready[p]))
					abort_run({names[p], " did not take write address and data together"});
				if (awvalid[p] && awready[p]) begin
					wr_v[p] = 1'b1;
					wr_addr[p] = aw[p].addr;
					wr_data[p] = w[p].data;
					wr_strb[p] = w[p].strb;
					exp_bresp[p] = out_of_range(aw[p].addr) ? SLVERR : OKAY;
					exp_b_v[p] = 1'b1;
				end
				if (arvalid[p] && arready[p]) begin
					rd_v[p] = 1'b1;
					rd_addr[p] = ar[p].addr;
				end
				if (bvalid[p] && bready[p]) begin
					if (!exp_b_v[p])
						abort_run({names[p], " gave a write response with no write pending"});
					check_value({names[p], "_bresp"}, 32'(exp_bresp[p]), 32'(bresp[p]));
					exp_b_v[p] = 1'b0;
				end
				if (rvalid[p] && rready[p]) begin
					if (!exp_r_v[p])
						abort_run({names[p], " gave a read response with no read pending"});
					check_value({names[p], "_r.data"}, exp_rdata[p], r[p].data);
					check_value({names[p], "_r.resp"}, 32'(exp_rresp[p]), 32'(r[p].resp));
					exp_r_v[p] = 1'b0;
				end
				// held response blocks new address handshakes
				if ((bvalid[p] && !bready[p]) || (rvalid[p] && !rready[p])) begin
					check_value({names[p], "_awready"}, '0, 32'(awready[p]));
					check_value({names[p], "_arready"}, '0, 32'(arready[p]));
				end
			end
		end
	end

	task automatic run_txn(input int p, input bit do_wr, input bit do_rd,
			input logic [`ADDR_W-1:0] waddr, input logic [`DATA_W-1:0] wdata,
			input logic [`STRB_W-1:0] strb, input logic [`ADDR_W-1:0] raddr,
			input int bstall, input int rstall);
		int cnt, t_aw, t_ar, t_b, t_r, b_held, r_held;
		bit b_done, r_done;
		cnt = 0;
		b_held = 0;
		r_held = 0;
		t_aw = -1;
		t_ar = -1;
		t_b = -1;
		t_r = -1;
		b_done = !do_wr;
		r_done = !do_rd;
		aw[p].addr = waddr;
		aw[p].prot = 3'(rand_bits(3));
		w[p].data = wdata;
		w[p].strb = strb;
		ar[p].addr = raddr;
		ar[p].prot = 3'(rand_bits(3));
		awvalid[p] = do_wr;
		wvalid[p] = do_wr;
		arvalid[p] = do_rd;
		bready[p] = do_wr && bstall == 0;
		rready[p] = do_rd && rstall == 0;
		while (!(b_done && r_done)) begin
			@(negedge clk);
			if (awvalid[p] && awready[p])
				t_aw = cycle;
			if (arvalid[p] && arready[p])
				t_ar = cycle;
			if (bvalid[p] && t_b < 0)
				t_b = cycle;
			if (rvalid[p] && t_r < 0)
				t_r = cycle;
			if (bvalid[p] && bready[p])
				b_done = 1'b1;
			if (rvalid[p] && rready[p])
				r_done = 1'b1;
			if (bvalid[p] && !bready[p])
				b_held++;
			if (rvalid[p] && !rready[p])
				r_held++;
			cnt++;
			if (cnt > 50)
				abort_run({names[p], " transaction got no handshake or response in 50 cycles"});
			@(posedge clk);
			#2;
			if (t_aw >= 0) begin
				awvalid[p] = 1'b0;
				wvalid[p] = 1'b0;
			end
			if (t_ar >= 0)
				arvalid[p] = 1'b0;
			bready[p] = !b_done && b_held >= bstall;
			rready[p] = !r_done && r_held >= rstall;
		end
		wr_lat = t_b - t_aw;
		rd_lat = t_r - t_ar;
	endtask

	task automatic random_txn(input int p);
		logic [1:0] kind;
		kind = 2'(rand_bits(2));
		run_txn(p, kind != 2'd1, kind != 2'd0, random_addr(), rand_bits(32),
			4'(rand_bits(4)), random_addr(), int'(rand_bits(2)), int'(rand_bits(2)));
	endtask

	initial begin
		int p;
		logic [`ADDR_W-1:0] a;
		rst_n = 1'b0;
		aw = '0;
		w = '0;
		ar = '0;
		awvalid = '0;
		wvalid = '0;
		arvalid = '0;
		bready = '0;
		rready = '0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (5) begin
			@(negedge clk);
			check_value("awready,wready,arready,bvalid,rvalid", '0,
				32'({awready, wready, arready, bvalid, rvalid}));
		end
		@(posedge clk);
		#2;
		for (int i = 0; i < 16; i++)
			run_txn(i % 2, 1'b1, 1'b0, 16'(i * 4), rand_bits(32), 4'hf, '0, 0, 0);
		// write on one port, read back on the other
		repeat (8) begin
			p = int'(rand_bits(1));
			a = {10'd0, 4'(rand_bits(4)), 2'b00};
			run_txn(p, 1'b1, 1'b0, a, rand_bits(32), 4'(rand_bits(4)), '0, 0, 0);
			run_txn(1 - p, 1'b0, 1'b1, '0, '0, '0, a, 0, 0);
		end
		a = {4'h1, 6'd0, 4'(rand_bits(4)), 2'b00};
		run_txn(0, 1'b1, 1'b0, a, rand_bits(32), 4'hf, '0, 0, 0);
		run_txn(0, 1'b0, 1'b1, '0, '0, '0, a, 0, 0);
		run_txn(1, 1'b0, 1'b1, '0, '0, '0, a & 16'h0fff, 0, 0);
		// earliest response timing
		run_txn(1, 1'b1, 1'b0, 16'h0008, rand_bits(32), 4'hf, '0, 0, 0);
		check_value("write latency", 1, 32'(wr_lat));
		run_txn(1, 1'b0, 1'b1, '0, '0, '0, 16'h0008, 0, 0);
		check_value("read latency", 2, 32'(rd_lat));
		run_txn(0, 1'b1, 1'b1, 16'h0010, rand_bits(32), 4'h5, 16'h0010, 4, 2);
		run_txn(1, 1'b1, 1'b1, 16'h0014, rand_bits(32), 4'ha, 16'h0018, 3, 3);
		fork
			run_txn(0, 1'b1, 1'b0, 16'h0020, rand_bits(32), 4'hf, '0, 0, 0);
			run_txn(1, 1'b1, 1'b0, 16'h0020, rand_bits(32), 4'h6, '0, 0, 0);
		join
		run_txn(0, 1'b0, 1'b1, '0, '0, '0, 16'h0020, 0, 0);
		fork
			repeat (300) random_txn(0);
			repeat (300) random_txn(1);
		join
		$display("** PASS **");
		$finish;
	end

endmodule
